/* source/rv_pkg.sv */
package rv_pkg;

  localparam int xlen     = 64;          // integer register width
  localparam int inst_w   = 32;          // base isa, no compressed
  localparam int reg_id_w = 5;           // x0..x31

  localparam logic [xlen-1:0] reset_pc = '0; // first fetch address

  // major opcodes, inst[6:0]
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_system = 7'b1110011;

  localparam logic [2:0] f3_addi = 3'b000;
  localparam logic [2:0] f3_sd   = 3'b011;   // doubleword store
  localparam logic [2:0] f3_priv = 3'b000;   // ecall/ebreak group

  localparam logic [11:0] f12_ebreak = 12'h001;

  typedef struct packed {
    logic [11:0] imm;     // imm[11:0]
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;   // imm[11:5]
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;   // imm[4:0]
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic [19:0] imm;     // imm[31:12]
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic        imm20;    // sign bit
    logic [9:0]  imm10_1;
    logic        imm11;
    logic [7:0]  imm19_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } j_fmt_t;

  typedef union packed {
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    u_fmt_t u_fmt;
    j_fmt_t j_fmt;
  } inst_u;

  typedef enum logic [2:0] {
    fetch, fetch_done, exec, store, store_done, halt
  } ctrl_state_e;

endpackage

/* source/dec_if.sv */
`timescale 1ns/1ps

interface dec_if import rv_pkg::*; ();

  inst_u                inst;     // latched instruction word
  logic [reg_id_w-1:0]  rd;
  logic [reg_id_w-1:0]  rs1;
  logic [reg_id_w-1:0]  rs2;
  logic [xlen-1:0]      imm;      // already sign extended
  logic                 need_imm; // operand b comes from imm
  logic                 is_addi;
  logic                 is_auipc;
  logic                 is_jal;
  logic                 is_store;
  logic                 is_ebreak;
  logic                 reg_wen;
  logic                 illegal;  // nothing in the subset matched

  modport dec (
    input  inst,
    output rd, rs1, rs2, imm, need_imm, is_addi, is_auipc, is_jal,
           is_store, is_ebreak, reg_wen, illegal
  );

  modport exe (
    input inst, rd, rs1, rs2, imm, need_imm, is_addi, is_auipc, is_jal,
          is_store, is_ebreak, reg_wen, illegal
  );

  modport ctl (input is_store, is_ebreak, is_jal, reg_wen, illegal);

endinterface

/* source/decoder.sv */
`timescale 1ns/1ps

module decoder import rv_pkg::*; (
  dec_if.dec d
);

  inst_u w;                 // local view of the word

  logic is_op_imm;          // opcode matches
  logic is_op_auipc;
  logic is_op_jal;
  logic is_op_store;
  logic is_op_system;

  logic addi;               // full instruction matches
  logic auipc;
  logic jal;
  logic sd;
  logic ebreak;

  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_u;
  logic [xlen-1:0] imm_j;
  logic [xlen-1:0] imm_s;

  assign w = d.inst;

  // opcode field sits at the same bits in every format
  assign is_op_imm    = (w.i_fmt.opcode == op_imm);
  assign is_op_auipc  = (w.i_fmt.opcode == op_auipc);
  assign is_op_jal    = (w.i_fmt.opcode == op_jal);
  assign is_op_store  = (w.i_fmt.opcode == op_store);
  assign is_op_system = (w.i_fmt.opcode == op_system);

  assign addi   = is_op_imm & (w.i_fmt.funct3 == f3_addi);
  assign auipc  = is_op_auipc;
  assign jal    = is_op_jal;
  assign sd     = is_op_store & (w.s_fmt.funct3 == f3_sd);
  assign ebreak = is_op_system & (w.i_fmt.funct3 == f3_priv)
                & (w.i_fmt.imm == f12_ebreak); // funct12 shares the i imm field

  // immediates per format, all sign extended to xlen
  assign imm_i = {{(xlen-12){w.i_fmt.imm[11]}}, w.i_fmt.imm};
  assign imm_u = {{(xlen-32){w.u_fmt.imm[19]}}, w.u_fmt.imm, 12'b0};
  assign imm_j = {{(xlen-21){w.j_fmt.imm20}}, w.j_fmt.imm20, w.j_fmt.imm19_12,
                  w.j_fmt.imm11, w.j_fmt.imm10_1, 1'b0};   // bit 0 always zero
  assign imm_s = {{(xlen-12){w.s_fmt.imm_hi[6]}}, w.s_fmt.imm_hi, w.s_fmt.imm_lo};

  // format flags are one-hot, so an and-or mux is enough
  assign d.imm = ({xlen{addi}}  & imm_i)
               | ({xlen{auipc}} & imm_u)
               | ({xlen{jal}}   & imm_j)
               | ({xlen{sd}}    & imm_s);

  assign d.rd  = w.i_fmt.rd;
  assign d.rs1 = w.i_fmt.rs1;
  assign d.rs2 = w.s_fmt.rs2;

  assign d.need_imm  = addi | auipc | sd;    // jal adds imm to pc, handled in exec
  assign d.is_addi   = addi;
  assign d.is_auipc  = auipc;
  assign d.is_jal    = jal;
  assign d.is_store  = sd;
  assign d.is_ebreak = ebreak;
  assign d.reg_wen   = ~sd;                  // ctrl masks it for halting cases

  assign d.illegal = ~(addi | auipc | jal | sd | ebreak);

endmodule

/* source/regfile.sv */
`timescale 1ns/1ps

module regfile import rv_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,
  input  logic [reg_id_w-1:0] rs1_id,
  input  logic [reg_id_w-1:0] rs2_id,
  output logic [xlen-1:0]     rs1_data,
  output logic [xlen-1:0]     rs2_data,
  input  logic                we,
  input  logic [reg_id_w-1:0] wd_id,
  input  logic [xlen-1:0]     wd_data
);

  logic [xlen-1:0] regs [1:31];   // x0 has no storage

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;            // architectural state starts at zero
      end
    end else if (we && (wd_id != '0)) begin
      regs[wd_id] <= wd_data;     // writes to x0 dropped here
    end
  end

  // async reads, x0 hardwired
  assign rs1_data = (rs1_id == '0) ? '0 : regs[rs1_id];
  assign rs2_data = (rs2_id == '0) ? '0 : regs[rs2_id];

endmodule

/* source/exec_unit.sv */
`timescale 1ns/1ps

module exec_unit import rv_pkg::*; (
  dec_if.exe              d,
  input  logic [xlen-1:0] pc,
  input  logic [xlen-1:0] rs1_data,
  input  logic [xlen-1:0] rs2_data,
  output logic [xlen-1:0] wb_data,
  output logic [xlen-1:0] next_pc,
  output logic [xlen-1:0] st_addr,
  output logic [xlen-1:0] st_data
);

  logic            use_pc;     // operand a is pc
  logic            use_imm;    // operand b is imm
  logic [xlen-1:0] op_a;
  logic [xlen-1:0] op_b;
  logic [xlen-1:0] sum;        // the one shared adder
  logic [xlen-1:0] pc_plus4;

  assign use_pc  = d.is_auipc | d.is_jal;
  assign use_imm = d.need_imm | d.is_jal;

  assign op_a = use_pc  ? pc    : rs1_data;  // addi, sd take rs1
  assign op_b = use_imm ? d.imm : rs2_data;  // rs2 path unused by the subset

  assign sum      = op_a + op_b;
  assign pc_plus4 = pc + xlen'(4);           // sequential pc, also the jal link

  // jal writes the link and jumps to the sum
  assign wb_data = d.is_jal ? pc_plus4 : sum;
  assign next_pc = d.is_jal ? sum      : pc_plus4;

  assign st_addr = sum;                      // rs1 + s-imm for sd
  assign st_data = rs2_data;

endmodule

/* source/core_ctrl.sv */
`timescale 1ns/1ps

module core_ctrl import rv_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  dec_if.ctl                c,
  output logic              imem_req,
  output logic [xlen-1:0]   imem_addr,
  input  logic              imem_ack,
  input  logic [inst_w-1:0] imem_rdata,
  output logic              dmem_req,
  output logic [xlen-1:0]   dmem_addr,
  output logic [xlen-1:0]   dmem_wdata,
  input  logic              dmem_ack,
  input  logic [xlen-1:0]   st_addr,
  input  logic [xlen-1:0]   st_data,
  input  logic [xlen-1:0]   next_pc,
  output logic [xlen-1:0]   pc,
  output inst_u             inst_q,
  output logic              rf_we,
  output logic              halted,
  output logic              illegal
);

  ctrl_state_e state;
  logic        stop;          // current instruction ends the run

  assign stop = c.illegal | c.is_ebreak;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= fetch;
      pc       <= reset_pc;
      imem_req <= 1'b0;
      dmem_req <= 1'b0;
      illegal  <= 1'b0;
    end else begin
      case (state)
        fetch: begin
          if (imem_req && imem_ack) begin
            imem_req <= 1'b0;                 // drop one cycle after ack seen
            state    <= fetch_done;
          end else if (!imem_req && !imem_ack) begin
            imem_req <= 1'b1;                 // ack low, safe to request
          end
        end
        fetch_done: if (!imem_ack) state <= exec; // wait phase 4
        exec: begin
          if (stop) begin
            illegal <= c.illegal;             // ebreak leaves it low
            state   <= halt;
          end else begin
            pc    <= next_pc;
            state <= c.is_store ? store : fetch;
          end
        end
        store: begin
          if (dmem_req && dmem_ack) begin
            dmem_req <= 1'b0;
            state    <= store_done;
          end else if (!dmem_req && !dmem_ack) begin
            dmem_req <= 1'b1;
          end
        end
        store_done: if (!dmem_ack) state <= fetch;
        halt:       state <= halt;            // only reset leaves
        default:    state <= halt;
      endcase
    end
  end

  // payload regs, only sampled under their state
  always_ff @(posedge clk) begin
    if (state == fetch && imem_req && imem_ack) inst_q <= imem_rdata;
    if (state == exec && c.is_store) begin
      dmem_addr  <= st_addr;                  // held for the whole store handshake
      dmem_wdata <= st_data;
    end
  end

  assign imem_addr = pc;                      // pc only moves in exec
  assign rf_we     = (state == exec) & c.reg_wen & ~stop;
  assign halted    = (state == halt);

endmodule

/* source/rv_core_top.sv */
`timescale 1ns/1ps

module rv_core_top import rv_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  output logic              imem_req,
  output logic [xlen-1:0]   imem_addr,
  input  logic              imem_ack,
  input  logic [inst_w-1:0] imem_rdata,
  output logic              dmem_req,
  output logic [xlen-1:0]   dmem_addr,
  output logic [xlen-1:0]   dmem_wdata,
  input  logic              dmem_ack,
  output logic              halted,
  output logic              illegal
);

  dec_if d_bus ();                // decoded fields shared by all blocks

  logic [xlen-1:0] pc;
  logic [xlen-1:0] rs1_data;
  logic [xlen-1:0] rs2_data;
  logic [xlen-1:0] wb_data;       // regfile write value
  logic [xlen-1:0] next_pc;
  logic [xlen-1:0] st_addr;
  logic [xlen-1:0] st_data;
  logic            rf_we;

  decoder i_decoder (.d(d_bus.dec));

  regfile i_regfile (
    .clk      (clk),
    .rst_n    (rst_n),
    .rs1_id   (d_bus.rs1),
    .rs2_id   (d_bus.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .we       (rf_we),
    .wd_id    (d_bus.rd),
    .wd_data  (wb_data)
  );

  exec_unit i_exec_unit (
    .d        (d_bus.exe),
    .pc       (pc),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wb_data  (wb_data),
    .next_pc  (next_pc),
    .st_addr  (st_addr),
    .st_data  (st_data)
  );

  core_ctrl i_core_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .c          (d_bus.ctl),
    .imem_req   (imem_req),
    .imem_addr  (imem_addr),
    .imem_ack   (imem_ack),
    .imem_rdata (imem_rdata),
    .dmem_req   (dmem_req),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_ack   (dmem_ack),
    .st_addr    (st_addr),
    .st_data    (st_data),
    .next_pc    (next_pc),
    .pc         (pc),
    .inst_q     (d_bus.inst),   // latched word feeds the decoder
    .rf_we      (rf_we),
    .halted     (halted),
    .illegal    (illegal)
  );

endmodule

/* sim/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen (
  input  logic rst_req,         // rising edge starts a fresh reset
  output logic clk,
  output logic rst_n
);

  initial clk = 1'b0;
  always #10 clk = ~clk;        // 20 ns period

  initial begin
    rst_n = 1'b0;
    forever begin
      repeat (8) @(posedge clk);  // 8 cycles in reset
      #1 rst_n = 1'b1;            // release just after the edge
      @(posedge rst_req);
      #1 rst_n = 1'b0;
    end
  end

endmodule

/* sim/tb_rv_core.sv */
`timescale 1ns/1ps

module tb_rv_core import rv_pkg::*; ();

  localparam int len_a      = 18;                          // words in program a
  localparam int len_b      = 5;
  localparam int max_cycles = (len_a + len_b) * 20 + 60;   // plus reset and idle waits

  logic              clk;
  logic              rst_n;
  logic              rst_req;
  logic              imem_req;
  logic [xlen-1:0]   imem_addr;
  logic              imem_ack;
  logic [inst_w-1:0] imem_rdata;
  logic              dmem_req;
  logic [xlen-1:0]   dmem_addr;
  logic [xlen-1:0]   dmem_wdata;
  logic              dmem_ack;
  logic              halted;
  logic              illegal;

  logic [inst_w-1:0] rom [0:63];   // instruction memory image
  logic [xlen-1:0]   exp_addr [$]; // expected stores, in order
  logic [xlen-1:0]   exp_data [$];
  logic              exp_illegal;
  int                exp_steps;    // instructions fetched up to the halt
  logic [31:0]       lcg_state = 32'h66d5_dbcc;
  int                mismatches = 0;
  int                failures = 0;
  int                cycles = 0;
  int                fetch_cnt = 0;
  int                store_cnt = 0;

  logic            prev_ireq = 1'b0;  // port state at the previous negedge
  logic            prev_iack = 1'b0;
  logic            prev_dreq = 1'b0;
  logic            prev_dack = 1'b0;
  logic [xlen-1:0] prev_iaddr;
  logic [xlen-1:0] prev_daddr;
  logic [xlen-1:0] prev_dwdata;

  tb_clk_gen i_clk_gen (.rst_req(rst_req), .clk(clk), .rst_n(rst_n));

  rv_core_top i_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .imem_req   (imem_req),
    .imem_addr  (imem_addr),
    .imem_ack   (imem_ack),
    .imem_rdata (imem_rdata),
    .dmem_req   (dmem_req),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_ack   (dmem_ack),
    .halted     (halted),
    .illegal    (illegal)
  );

  function automatic int unsigned rand_delay();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:30];       // high bits, 0..3 cycles
  endfunction

  function automatic logic [31:0] itype_word(logic [6:0] op, logic [4:0] rd, logic [2:0] f3,
                                             logic [4:0] rs1, logic [11:0] imm);
    inst_u w;
    w.i_fmt = {imm, rs1, f3, rd, op};
    return w;
  endfunction

  function automatic logic [31:0] stype_word(logic [4:0] rs2, logic [4:0] rs1, logic [11:0] imm);
    inst_u w;
    w.s_fmt = {imm[11:5], rs2, rs1, f3_sd, imm[4:0], op_store};
    return w;
  endfunction

  function automatic logic [31:0] utype_word(logic [4:0] rd, logic [19:0] imm);
    inst_u w;
    w.u_fmt = {imm, rd, op_auipc};
    return w;
  endfunction

  function automatic logic [31:0] jtype_word(logic [4:0] rd, logic [20:0] off);
    inst_u w;
    w.j_fmt = {off[20], off[10:1], off[11], off[19:12], rd, op_jal};  // jal bit scramble
    return w;
  endfunction

  // isa model, walks the rom image until ebreak or an unsupported word
  function automatic void run_reference();
    logic [xlen-1:0] x [0:31];
    logic [xlen-1:0] pc;
    logic [xlen-1:0] imm;
    inst_u           w;
    bit              done;
    for (int i = 0; i < 32; i++) x[i] = '0;
    pc = reset_pc;
    done = 1'b0;
    exp_steps = 0;
    exp_addr.delete();
    exp_data.delete();
    while (!done && exp_steps < 64) begin
      w = rom[pc[7:2]];
      exp_steps++;
      if (w.i_fmt.opcode == op_imm && w.i_fmt.funct3 == f3_addi) begin
        x[w.i_fmt.rd] = x[w.i_fmt.rs1] + {{52{w.i_fmt.imm[11]}}, w.i_fmt.imm};
        pc = pc + 4;
      end else if (w.u_fmt.opcode == op_auipc) begin
        x[w.u_fmt.rd] = pc + {{32{w.u_fmt.imm[19]}}, w.u_fmt.imm, 12'h000};
        pc = pc + 4;
      end else if (w.j_fmt.opcode == op_jal) begin
        imm = {{43{w.j_fmt.imm20}}, w.j_fmt.imm20, w.j_fmt.imm19_12, w.j_fmt.imm11,
               w.j_fmt.imm10_1, 1'b0};
        x[w.j_fmt.rd] = pc + 4;            // link is the next sequential pc
        pc = pc + imm;
      end else if (w.s_fmt.opcode == op_store && w.s_fmt.funct3 == f3_sd) begin
        imm = {{52{w.s_fmt.imm_hi[6]}}, w.s_fmt.imm_hi, w.s_fmt.imm_lo};
        exp_addr.push_back(x[w.s_fmt.rs1] + imm);
        exp_data.push_back(x[w.s_fmt.rs2]);
        pc = pc + 4;
      end else begin
        done = 1'b1;                       // ebreak and unsupported both stop
        exp_illegal = !(w.i_fmt.opcode == op_system && w.i_fmt.funct3 == f3_priv
                        && w.i_fmt.imm == f12_ebreak);
      end
      x[0] = '0;                           // x0 stays zero
    end
  endfunction

  task automatic load_program(int which);
    for (int i = 0; i < 64; i++) rom[i] = {i[15:0], 16'h0000};  // opcode 0, never legal
    if (which == 0) begin
      rom[0]  = itype_word(op_imm, 5'd1, f3_addi, 5'd0, 12'd100);
      rom[1]  = itype_word(op_imm, 5'd2, f3_addi, 5'd1, -12'sd37);
      rom[2]  = itype_word(op_imm, 5'd0, f3_addi, 5'd1, 12'd5);     // x0 write dropped
      rom[3]  = itype_word(op_imm, 5'd3, f3_addi, 5'd0, 12'h800);   // most negative imm
      rom[4]  = stype_word(5'd2, 5'd1, 12'd8);
      rom[5]  = stype_word(5'd0, 5'd3, -12'sd4);
      rom[6]  = stype_word(5'd3, 5'd2, 12'd0);
      rom[7]  = utype_word(5'd4, 20'h12345);
      rom[8]  = stype_word(5'd4, 5'd0, 12'd16);
      rom[9]  = jtype_word(5'd5, 21'd8);                            // skips word 10
      rom[10] = itype_word(op_imm, 5'd6, f3_addi, 5'd0, 12'd1);
      rom[11] = stype_word(5'd5, 5'd0, 12'd24);
      rom[12] = stype_word(5'd6, 5'd0, 12'd32);
      rom[13] = utype_word(5'd7, 20'hfffff);
      rom[14] = stype_word(5'd7, 5'd0, 12'd40);
      rom[15] = itype_word(op_imm, 5'd8, f3_addi, 5'd7, 12'd2047);
      rom[16] = stype_word(5'd8, 5'd0, -12'sd8);
      rom[17] = itype_word(op_system, 5'd0, f3_priv, 5'd0, f12_ebreak);
    end else begin
      rom[0] = itype_word(op_imm, 5'd1, f3_addi, 5'd0, 12'd7);
      rom[1] = stype_word(5'd1, 5'd0, 12'd0);
      rom[2] = 32'h0020_80b3;                                      // add, outside the subset
      rom[3] = stype_word(5'd1, 5'd0, 12'd8);
      rom[4] = itype_word(op_system, 5'd0, f3_priv, 5'd0, f12_ebreak);
    end
    run_reference();
  endtask

  task automatic report_mismatch(string what, logic [63:0] got, logic [63:0] exp);
    mismatches++;
    $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
  endtask

  task automatic report_failure(string what);
    failures++;
    $display("error at %0t: %s", $time, what);
  endtask

  task automatic check_idle();
    if (imem_req !== 1'b0) report_mismatch("imem_req after reset", imem_req, 0);
    if (dmem_req !== 1'b0) report_mismatch("dmem_req after reset", dmem_req, 0);
    if (halted !== 1'b0) report_mismatch("halted after reset", halted, 0);
    if (illegal !== 1'b0) report_mismatch("illegal after reset", illegal, 0);
  endtask

  task automatic check_halt();
    int fetches;
    int stores;
    wait (halted === 1'b1);
    @(negedge clk);
    #1;
    if (illegal !== exp_illegal) report_mismatch("illegal at halt", illegal, exp_illegal);
    if (fetch_cnt != exp_steps) report_mismatch("fetch count", fetch_cnt, exp_steps);
    if (exp_addr.size() != 0) report_failure("core halted before all expected stores");
    fetches = fetch_cnt;
    stores = store_cnt;
    repeat (10) @(posedge clk);
    #1;                                // outputs settled after the edge
    if (fetch_cnt != fetches || store_cnt != stores
        || imem_req !== 1'b0 || dmem_req !== 1'b0) begin
      report_failure("memory request seen after halt");
    end
  endtask

  always begin : imem_model
    int dly;
    @(posedge clk);
    #1;
    if (rst_n && imem_req && !imem_ack) begin
      dly = rand_delay();
      repeat (dly) begin
        @(posedge clk);
        #1;
      end
      imem_rdata = rom[imem_addr[7:2]];
      imem_ack = 1'b1;
      while (imem_req) begin             // phase 3, core drops req
        @(posedge clk);
        #1;
      end
      dly = rand_delay();
      repeat (dly) begin
        @(posedge clk);
        #1;
      end
      imem_ack = 1'b0;
    end
  end

  // store responder, compares each store against the reference list
  always begin : dmem_model
    int dly;
    @(posedge clk);
    #1;
    if (rst_n && dmem_req && !dmem_ack) begin
      dly = rand_delay();
      repeat (dly) begin
        @(posedge clk);
        #1;
      end
      if (exp_addr.size() == 0) begin
        report_failure("store seen that the reference model does not make");
      end else begin
        if (dmem_addr !== exp_addr[0]) report_mismatch("store address", dmem_addr, exp_addr[0]);
        if (dmem_wdata !== exp_data[0]) report_mismatch("store data", dmem_wdata, exp_data[0]);
        void'(exp_addr.pop_front());
        void'(exp_data.pop_front());
      end
      dmem_ack = 1'b1;
      while (dmem_req) begin
        @(posedge clk);
        #1;
      end
      dly = rand_delay();
      repeat (dly) begin
        @(posedge clk);
        #1;
      end
      dmem_ack = 1'b0;
    end
  end

  // four-phase monitor, sampled mid-cycle where everything is settled
  always @(negedge clk) begin
    if (rst_n) begin
      if (imem_req && !prev_ireq) begin
        fetch_cnt++;
        if (prev_iack) report_failure("imem_req rose while imem_ack was high");
      end
      if (imem_req && prev_ireq && imem_addr !== prev_iaddr) begin
        report_failure("imem_addr changed while imem_req was high");
      end
      if (!imem_req && prev_ireq && !prev_iack) report_failure("imem_req dropped before ack");
      if (dmem_req && !prev_dreq) begin
        store_cnt++;
        if (prev_dack) report_failure("dmem_req rose while dmem_ack was high");
      end
      if (dmem_req && prev_dreq && (dmem_addr !== prev_daddr || dmem_wdata !== prev_dwdata)) begin
        report_failure("dmem address or data changed while dmem_req was high");
      end
      if (!dmem_req && prev_dreq && !prev_dack) report_failure("dmem_req dropped before ack");
    end
    prev_ireq = imem_req;
    prev_iack = imem_ack;
    prev_iaddr = imem_addr;
    prev_dreq = dmem_req;
    prev_dack = dmem_ack;
    prev_daddr = dmem_addr;
    prev_dwdata = dmem_wdata;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= max_cycles) begin
      $display("timeout: the core did not finish within %0d cycles", max_cycles);
      $display("summary: %0d mismatches, %0d other errors", mismatches, failures);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  initial begin
    rst_req = 1'b0;
    imem_ack = 1'b0;
    imem_rdata = '0;
    dmem_ack = 1'b0;
    load_program(0);
    @(posedge rst_n);
    check_idle();
    @(posedge clk);
    #2;
    if (imem_req !== 1'b1) report_failure("no fetch on the first clock after reset");
    if (imem_addr !== reset_pc) report_mismatch("first fetch address", imem_addr, reset_pc);
    check_halt();                      // program a, ends on ebreak
    load_program(1);
    fetch_cnt = 0;
    store_cnt = 0;
    @(posedge clk);
    #1 rst_req = 1'b1;
    @(posedge clk);
    #1 rst_req = 1'b0;
    @(posedge rst_n);
    check_idle();
    check_halt();                      // program b, ends on an unsupported opcode
    $display("summary: %0d mismatches, %0d other errors", mismatches, failures);
    if (mismatches + failures == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* list.f */
source/rv_pkg.sv
source/dec_if.sv
source/decoder.sv
source/regfile.sv
source/exec_unit.sv
source/core_ctrl.sv
source/rv_core_top.sv
sim/tb_clk_gen.sv
sim/tb_rv_core.sv

/* Bender.yml */
package:
  name: rv_core

sources:
  - files:
      - source/rv_pkg.sv
      - source/dec_if.sv
      - source/decoder.sv
      - source/regfile.sv
      - source/exec_unit.sv
      - source/core_ctrl.sv
      - source/rv_core_top.sv
  - target: simulation
    files:
      - sim/tb_clk_gen.sv
      - sim/tb_rv_core.sv
